// ==== design/f2x_pkg.sv ====
/* float to fixed shared definitions */
package f2x_pkg;

    // default formats are fixed Q8.8 and a half-like float
    localparam int DEF_INT_W  = 8;
    localparam int DEF_FRAC_W = 8;
    localparam int DEF_EXP_W  = 5;
    localparam int DEF_MANT_W = 10;

    // wide enough for EXP_W up to 6
    localparam int SHIFT_W = 8;

    // positive shifts left, negative shifts right
    typedef logic signed [SHIFT_W-1:0] shift_t;

    typedef logic [1:0] fp_class_t;

    // exponent zero flushes and all ones is inf or nan
    localparam fp_class_t CLS_ZERO    = 2'd0;
    localparam fp_class_t CLS_NORMAL  = 2'd1;
    localparam fp_class_t CLS_SPECIAL = 2'd2;

endpackage

// ==== design/float_decoder.sv ====
/* float field decode, stage 1 */
`timescale 1ns/1ns
module float_decoder #(
    parameter int EXP_W  = f2x_pkg::DEF_EXP_W,
    parameter int MANT_W = f2x_pkg::DEF_MANT_W
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  in_valid,
    input  logic [EXP_W+MANT_W:0] float_in,
    output logic                  d_valid,
    output logic                  d_sign,
    output logic [EXP_W-1:0]      d_exponent,
    output logic [MANT_W:0]       d_mantissa,
    output f2x_pkg::fp_class_t    d_class
);
    import f2x_pkg::*;

    logic [EXP_W-1:0]  exp_field;
    logic [MANT_W-1:0] mant_field;
    fp_class_t         cls;

    assign exp_field  = float_in[EXP_W+MANT_W-1:MANT_W];
    assign mant_field = float_in[MANT_W-1:0];

    always_comb begin
        if (exp_field == '0) begin
            cls = CLS_ZERO;
        end else if (&exp_field) begin
            cls = CLS_SPECIAL;
        end else begin
            cls = CLS_NORMAL;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            d_valid <= 1'b0;
        end else begin
            d_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid) begin
            d_sign     <= float_in[EXP_W+MANT_W];
            d_exponent <= exp_field;
            // hidden leading one
            d_mantissa <= {1'b1, mant_field};
            d_class    <= cls;
        end
    end

endmodule

// ==== design/shift_amount_calc.sv ====
/* shift amount, stage 2 */
`timescale 1ns/1ns
module shift_amount_calc #(
    parameter int EXP_W  = f2x_pkg::DEF_EXP_W,
    parameter int MANT_W = f2x_pkg::DEF_MANT_W,
    parameter int FRAC_W = f2x_pkg::DEF_FRAC_W
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               d_valid,
    input  logic               d_sign,
    input  logic [EXP_W-1:0]   d_exponent,
    input  logic [MANT_W:0]    d_mantissa,
    input  f2x_pkg::fp_class_t d_class,
    output logic               s_valid,
    output logic               s_sign,
    output f2x_pkg::shift_t    s_shift,
    output logic [MANT_W:0]    s_mantissa,
    output f2x_pkg::fp_class_t s_class
);
    import f2x_pkg::*;

    localparam int BIAS = (1 << (EXP_W - 1)) - 1;
    // moves the mantissa lsb onto the fixed-point lsb
    localparam int OFFSET = FRAC_W - MANT_W - BIAS;

    shift_t shift_next;

    assign shift_next = shift_t'(int'(d_exponent) + OFFSET);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            s_valid <= 1'b0;
        end else begin
            s_valid <= d_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (d_valid) begin
            s_sign     <= d_sign;
            s_shift    <= shift_next;
            s_mantissa <= d_mantissa;
            s_class    <= d_class;
        end
    end

endmodule

// ==== design/mantissa_shifter.sv ====
/* barrel shifter, stage 3 */
`timescale 1ns/1ns
module mantissa_shifter #(
    parameter int MANT_W = f2x_pkg::DEF_MANT_W,
    parameter int INT_W  = f2x_pkg::DEF_INT_W,
    parameter int FRAC_W = f2x_pkg::DEF_FRAC_W
) (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            s_valid,
    input  logic                            s_sign,
    input  f2x_pkg::shift_t                 s_shift,
    input  logic [MANT_W:0]                 s_mantissa,
    input  f2x_pkg::fp_class_t              s_class,
    output logic                            b_valid,
    output logic                            b_sign,
    output logic [MANT_W+INT_W+FRAC_W:0]    b_mag,
    output f2x_pkg::fp_class_t              b_class
);
    import f2x_pkg::*;

    localparam int OUT_W = MANT_W + INT_W + FRAC_W + 1;
    // largest left shift that keeps the leading one inside the field
    localparam int LEFT_MAX = INT_W + FRAC_W;

    logic               shift_left;
    logic [SHIFT_W-1:0] abs_shift;
    logic [OUT_W-1:0]   lsh [SHIFT_W+1];
    logic [OUT_W-1:0]   rsh [SHIFT_W+1];
    logic [OUT_W-1:0]   mag_next;

    assign shift_left = ~s_shift[SHIFT_W-1];
    assign abs_shift  = shift_left ? s_shift : -s_shift;

    assign lsh[0] = {{(OUT_W-MANT_W-1){1'b0}}, s_mantissa};
    assign rsh[0] = {{(OUT_W-MANT_W-1){1'b0}}, s_mantissa};

    // one mux layer per shift bit
    for (genvar i = 0; i < SHIFT_W; i++) begin : g_layer
        assign lsh[i+1] = abs_shift[i] ? (lsh[i] << (2 ** i)) : lsh[i];
        assign rsh[i+1] = abs_shift[i] ? (rsh[i] >> (2 ** i)) : rsh[i];
    end

    always_comb begin
        if (!shift_left) begin
            // truncates toward zero
            mag_next = rsh[SHIFT_W];
        end else if (abs_shift > LEFT_MAX) begin
            // bits would fall off the top so force saturation downstream
            mag_next = '1;
        end else begin
            mag_next = lsh[SHIFT_W];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            b_valid <= 1'b0;
        end else begin
            b_valid <= s_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (s_valid) begin
            b_sign  <= s_sign;
            b_mag   <= mag_next;
            b_class <= s_class;
        end
    end

endmodule

// ==== design/fixed_postproc.sv ====
/* saturation and sign, stage 4 */
`timescale 1ns/1ns
module fixed_postproc #(
    parameter int INT_W  = f2x_pkg::DEF_INT_W,
    parameter int FRAC_W = f2x_pkg::DEF_FRAC_W,
    parameter int MANT_W = f2x_pkg::DEF_MANT_W
) (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         b_valid,
    input  logic                         b_sign,
    input  logic [MANT_W+INT_W+FRAC_W:0] b_mag,
    input  f2x_pkg::fp_class_t           b_class,
    output logic                         out_valid,
    output logic [INT_W+FRAC_W-1:0]      fixed_out,
    output logic                         overflow
);
    import f2x_pkg::*;

    localparam int W     = INT_W + FRAC_W;
    localparam int OUT_W = MANT_W + W + 1;

    // magnitude limit is 2^(W-1) for negative and one less for positive
    localparam logic [OUT_W-1:0] NEG_LIM  = {{(OUT_W-1){1'b0}}, 1'b1} << (W - 1);
    localparam logic [OUT_W-1:0] POS_LIM  = NEG_LIM - 1'b1;
    localparam logic [W-1:0]     MAX_CODE = {1'b0, {(W-1){1'b1}}};
    localparam logic [W-1:0]     MIN_CODE = {1'b1, {(W-1){1'b0}}};

    logic [OUT_W-1:0] limit;
    logic [W-1:0]     sat_code;
    logic [W-1:0]     fixed_next;
    logic             ovf_next;

    assign limit    = b_sign ? NEG_LIM : POS_LIM;
    assign sat_code = b_sign ? MIN_CODE : MAX_CODE;

    always_comb begin
        case (b_class)
            CLS_ZERO: begin
                fixed_next = '0;
                ovf_next   = 1'b0;
            end
            CLS_SPECIAL: begin
                fixed_next = sat_code;
                ovf_next   = 1'b1;
            end
            default: begin
                if (b_mag > limit) begin
                    fixed_next = sat_code;
                    ovf_next   = 1'b1;
                end else begin
                    fixed_next = b_sign ? -b_mag[W-1:0] : b_mag[W-1:0];
                    ovf_next   = 1'b0;
                end
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            overflow  <= 1'b0;
        end else begin
            out_valid <= b_valid;
            overflow  <= b_valid & ovf_next;
        end
    end

    always_ff @(posedge clk) begin
        if (b_valid) begin
            fixed_out <= fixed_next;
        end
    end

endmodule

// ==== design/float_to_fixed.sv ====
/* float to fixed converter */
`timescale 1ns/1ns
module float_to_fixed #(
    parameter int INT_W  = f2x_pkg::DEF_INT_W,
    parameter int FRAC_W = f2x_pkg::DEF_FRAC_W,
    parameter int EXP_W  = f2x_pkg::DEF_EXP_W,
    parameter int MANT_W = f2x_pkg::DEF_MANT_W
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    in_valid,
    input  logic [EXP_W+MANT_W:0]   float_in,
    output logic                    out_valid,
    output logic [INT_W+FRAC_W-1:0] fixed_out,
    output logic                    overflow
);
    import f2x_pkg::*;

    // stage 1 outputs
    logic                         d_valid;
    logic                         d_sign;
    logic [EXP_W-1:0]             d_exponent;
    logic [MANT_W:0]              d_mantissa;
    fp_class_t                    d_class;

    // stage 2 outputs
    logic                         s_valid;
    logic                         s_sign;
    shift_t                       s_shift;
    logic [MANT_W:0]              s_mantissa;
    fp_class_t                    s_class;

    // stage 3 outputs
    logic                         b_valid;
    logic                         b_sign;
    logic [MANT_W+INT_W+FRAC_W:0] b_mag;
    fp_class_t                    b_class;

    float_decoder #(
        .EXP_W (EXP_W),
        .MANT_W(MANT_W)
    ) u_float_decoder (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .float_in  (float_in),
        .d_valid   (d_valid),
        .d_sign    (d_sign),
        .d_exponent(d_exponent),
        .d_mantissa(d_mantissa),
        .d_class   (d_class)
    );

    shift_amount_calc #(
        .EXP_W (EXP_W),
        .MANT_W(MANT_W),
        .FRAC_W(FRAC_W)
    ) u_shift_amount_calc (
        .clk       (clk),
        .rst_n     (rst_n),
        .d_valid   (d_valid),
        .d_sign    (d_sign),
        .d_exponent(d_exponent),
        .d_mantissa(d_mantissa),
        .d_class   (d_class),
        .s_valid   (s_valid),
        .s_sign    (s_sign),
        .s_shift   (s_shift),
        .s_mantissa(s_mantissa),
        .s_class   (s_class)
    );

    mantissa_shifter #(
        .MANT_W(MANT_W),
        .INT_W (INT_W),
        .FRAC_W(FRAC_W)
    ) u_mantissa_shifter (
        .clk       (clk),
        .rst_n     (rst_n),
        .s_valid   (s_valid),
        .s_sign    (s_sign),
        .s_shift   (s_shift),
        .s_mantissa(s_mantissa),
        .s_class   (s_class),
        .b_valid   (b_valid),
        .b_sign    (b_sign),
        .b_mag     (b_mag),
        .b_class   (b_class)
    );

    fixed_postproc #(
        .INT_W (INT_W),
        .FRAC_W(FRAC_W),
        .MANT_W(MANT_W)
    ) u_fixed_postproc (
        .clk      (clk),
        .rst_n    (rst_n),
        .b_valid  (b_valid),
        .b_sign   (b_sign),
        .b_mag    (b_mag),
        .b_class  (b_class),
        .out_valid(out_valid),
        .fixed_out(fixed_out),
        .overflow (overflow)
    );

endmodule

// ==== verif/float_to_fixed_sva.sv ====
/* converter protocol assertions */
`timescale 1ns/1ns
module float_to_fixed_sva (
    input logic clk,
    input logic rst_n,
    input logic in_valid,
    input logic out_valid,
    input logic overflow
);

    // failures seen so far
    int fail_count = 0;

    // fixed four cycle latency once the pipe has been out of reset
    property p_latency;
        @(posedge clk) disable iff (!rst_n)
            ($past(rst_n, 1) && $past(rst_n, 2) && $past(rst_n, 3) && $past(rst_n, 4))
            |-> (out_valid == $past(in_valid, 4));
    endproperty

    property p_reset_clears;
        @(posedge clk) !rst_n |=> (!out_valid && !overflow);
    endproperty

    // first cycle after release
    property p_release_quiet;
        @(posedge clk) $rose(rst_n) |=> (!out_valid && !overflow);
    endproperty

    property p_ovf_needs_valid;
        @(posedge clk) disable iff (!rst_n) overflow |-> out_valid;
    endproperty

    property p_valid_known;
        @(posedge clk) disable iff (!rst_n) !$isunknown(out_valid);
    endproperty

    a_latency: assert property (p_latency)
        else begin
            fail_count++;
            $error("out_valid does not follow in_valid four cycles later");
        end
    a_reset_clears: assert property (p_reset_clears)
        else begin
            fail_count++;
            $error("out_valid or overflow set during reset");
        end
    a_release_quiet: assert property (p_release_quiet)
        else begin
            fail_count++;
            $error("out_valid or overflow set in the first cycle after reset");
        end
    a_ovf_needs_valid: assert property (p_ovf_needs_valid)
        else begin
            fail_count++;
            $error("overflow high without out_valid");
        end
    a_valid_known: assert property (p_valid_known)
        else begin
            fail_count++;
            $error("out_valid is unknown");
        end

endmodule

bind float_to_fixed float_to_fixed_sva u_float_to_fixed_sva (
    .clk      (clk),
    .rst_n    (rst_n),
    .in_valid (in_valid),
    .out_valid(out_valid),
    .overflow (overflow)
);

// ==== verif/tb_float_to_fixed.sv ====
/* float to fixed testbench */
`timescale 1ns/1ns
module tb_float_to_fixed;

    localparam int INT_W      = 8;
    localparam int FRAC_W     = 8;
    localparam int EXP_W      = 5;
    localparam int MANT_W     = 10;
    localparam int W          = INT_W + FRAC_W;
    localparam int FP_W       = 1 + EXP_W + MANT_W;
    localparam int LATENCY    = 4;
    localparam int CLK_PERIOD = 10;
    localparam int N_DIRECTED = 13;
    localparam int N_RANDOM   = 2000;
    localparam int N_CYCLES   = N_DIRECTED + N_RANDOM;
    localparam logic [31:0] SEED = 32'h0f97e25b;

    logic            clk;
    logic            rst_n;
    logic            in_valid;
    logic [FP_W-1:0] float_in;
    logic            out_valid;
    logic [W-1:0]    fixed_out;
    logic            overflow;

    logic [31:0]  rng_state;
    int           cycle_cnt;
    int           in_count;
    int           out_count;
    int           value_errors;
    int           protocol_errors;
    // expected results in input order with their drive cycle
    logic [W-1:0] exp_fixed_q[$];
    logic         exp_ovf_q[$];
    int           exp_cycle_q[$];

    float_to_fixed #(
        .INT_W (INT_W),
        .FRAC_W(FRAC_W),
        .EXP_W (EXP_W),
        .MANT_W(MANT_W)
    ) UUT (
        .clk      (clk),
        .rst_n    (rst_n),
        .in_valid (in_valid),
        .float_in (float_in),
        .out_valid(out_valid),
        .fixed_out(fixed_out),
        .overflow (overflow)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [FP_W-1:0] make_float(input logic s, input int e, input int m);
        return {s, EXP_W'(e), MANT_W'(m)};
    endfunction

    // value of 1.m * 2^(e-bias) scaled by 2^FRAC_W and truncated toward zero
    function automatic void convert_ref(input logic [FP_W-1:0] f,
                                        output logic [W-1:0] fx,
                                        output logic ovf);
        logic   sign;
        int     e;
        int     shift;
        longint mag;
        longint limit;
        longint result;
        sign  = f[FP_W-1];
        e     = int'(f[FP_W-2:MANT_W]);
        shift = e - (2 ** (EXP_W - 1) - 1) - MANT_W + FRAC_W;
        limit = longint'(1) <<< (W - 1);
        if (!sign) begin
            limit = limit - 1;
        end
        mag = (longint'(1) <<< MANT_W) + longint'(f[MANT_W-1:0]);
        if (shift > W) begin
            mag = limit + 1;
        end else if (shift >= 0) begin
            mag = mag <<< shift;
        end else begin
            mag = mag >>> (-shift);
        end
        ovf = 1'b0;
        if (e == 0) begin
            result = 0;
        end else if (e == 2 ** EXP_W - 1 || mag > limit) begin
            ovf    = 1'b1;
            result = sign ? -limit : limit;
        end else begin
            result = sign ? -mag : mag;
        end
        fx = result[W-1:0];
    endfunction

    task automatic drive(input logic v, input logic [FP_W-1:0] f);
        logic [W-1:0] fx;
        logic         ovf;
        in_valid = v;
        float_in = f;
        if (v) begin
            convert_ref(f, fx, ovf);
            exp_fixed_q.push_back(fx);
            exp_ovf_q.push_back(ovf);
            exp_cycle_q.push_back(cycle_cnt);
            in_count++;
        end
        @(posedge clk);
        #1;
    endtask

    task automatic check_output();
        logic [W-1:0] exp_fx;
        logic         exp_ovf;
        int           tag;
        exp_fx  = exp_fixed_q.pop_front();
        exp_ovf = exp_ovf_q.pop_front();
        tag     = exp_cycle_q.pop_front();
        assert (fixed_out === exp_fx) else begin
            value_errors++;
            $display("ERR %0t fixed_out expected %h got %h", $time, exp_fx, fixed_out);
        end
        assert (overflow === exp_ovf) else begin
            value_errors++;
            $display("ERR %0t overflow expected %b got %b", $time, exp_ovf, overflow);
        end
        assert (cycle_cnt - tag == LATENCY) else begin
            protocol_errors++;
            $display("result at %0t came %0d cycles after its input instead of %0d",
                     $time, cycle_cnt - tag, LATENCY);
        end
    endtask

    // outputs are stable at the falling edge
    always @(negedge clk) begin
        if (rst_n === 1'b1 && out_valid === 1'b1) begin
            out_count++;
            assert (exp_fixed_q.size() > 0) else begin
                protocol_errors++;
                $display("output at %0t arrived with no conversion pending", $time);
            end
            if (exp_fixed_q.size() > 0) begin
                check_output();
            end
        end
    end

    // zeros, specials, saturation edges and truncation
    task automatic run_directed();
        drive(1'b1, make_float(1'b0, 0, 0));
        drive(1'b1, make_float(1'b1, 0, 'h155));
        drive(1'b1, make_float(1'b0, 31, 0));
        drive(1'b1, make_float(1'b1, 31, 'h201));
        drive(1'b0, make_float(1'b0, 15, 0));
        drive(1'b1, make_float(1'b1, 22, 0));
        drive(1'b1, make_float(1'b0, 22, 0));
        drive(1'b1, make_float(1'b0, 21, 'h3ff));
        drive(1'b1, make_float(1'b0, 15, 0));
        drive(1'b1, make_float(1'b1, 15, 'h200));
        drive(1'b1, make_float(1'b0, 8, 'h3ff));
        drive(1'b1, make_float(1'b1, 6, 'h3ff));
        drive(1'b1, make_float(1'b1, 30, 'h155));
    endtask

    task automatic run_random();
        logic            v;
        logic [FP_W-1:0] f;
        for (int i = 0; i < N_RANDOM; i++) begin
            rng_state = xorshift(rng_state);
            // about three in four cycles carry data
            v = (rng_state[31:30] != 2'b00);
            f = rng_state[FP_W-1:0];
            drive(v, f);
        end
    endtask

    initial begin
        rng_state       = SEED;
        cycle_cnt       = 0;
        in_count        = 0;
        out_count       = 0;
        value_errors    = 0;
        protocol_errors = 0;
        rst_n           = 1'b0;
        in_valid        = 1'b0;
        float_in        = '0;
        repeat (3) @(posedge clk);
        #1;
        rst_n = 1'b1;
        run_directed();
        run_random();
        in_valid = 1'b0;
        for (int i = 0; i < 2 * LATENCY && exp_fixed_q.size() != 0; i++) begin
            @(posedge clk);
        end
        @(negedge clk);
        assert (exp_fixed_q.size() == 0) else begin
            protocol_errors++;
            $display("%0d conversions never produced an output", exp_fixed_q.size());
        end
        assert (out_count == in_count) else begin
            protocol_errors++;
            $display("%0d inputs were accepted but %0d outputs came out", in_count, out_count);
        end
        $display("summary: %0d inputs, %0d outputs, %0d value errors, %0d protocol errors, %0d %s",
                 in_count, out_count, value_errors, protocol_errors,
                 UUT.u_float_to_fixed_sva.fail_count, "assertion failures");
        if (value_errors + protocol_errors + UUT.u_float_to_fixed_sva.fail_count == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

    initial begin
        #((N_CYCLES + 20) * CLK_PERIOD);
        $display("watchdog expired before the run completed");
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

// ==== all.f ====
design/f2x_pkg.sv
design/float_decoder.sv
design/shift_amount_calc.sv
design/mantissa_shifter.sv
design/fixed_postproc.sv
design/float_to_fixed.sv
verif/float_to_fixed_sva.sv
verif/tb_float_to_fixed.sv

// ==== Bender.yml ====
package:
  name: float_to_fixed

sources:
  - files:
      - design/f2x_pkg.sv
      - design/float_decoder.sv
      - design/shift_amount_calc.sv
      - design/mantissa_shifter.sv
      - design/fixed_postproc.sv
      - design/float_to_fixed.sv

  - target: verif
    files:
      - verif/float_to_fixed_sva.sv
      - verif/tb_float_to_fixed.sv
